//--- common/nocPkg.sv
package nocPkg;

  // Router ports, listed in base priority order
  localparam int numPorts = 5;
  localparam int portLocal = 0;
  localparam int portNorth = 1;
  localparam int portEast = 2;
  localparam int portSouth = 3;
  localparam int portWest = 4;

  // Mesh size
  localparam int meshWidth = 4;
  localparam int meshHeight = 4;

  // One coordinate must cover the larger mesh dimension
  localparam int coordWidth = $clog2((meshWidth > meshHeight) ? meshWidth : meshHeight);

  // Fixed position of this router in the mesh
  localparam logic [coordWidth-1:0] routerX = coordWidth'(1);
  localparam logic [coordWidth-1:0] routerY = coordWidth'(2);

  // Packet length in flits, header included
  localparam int lengthWidth = 12;

  // Flit kind codes
  localparam int flitIdWidth = 3;
  localparam logic [flitIdWidth-1:0] flitHeader = 3'b001;
  localparam logic [flitIdWidth-1:0] flitBody = 3'b010;
  localparam logic [flitIdWidth-1:0] flitTail = 3'b100;

  localparam int dataWidth = 16;

  // One data word, read as a header or as plain payload
  typedef union packed {
    struct packed {
      logic [coordWidth-1:0] destX;
      logic [coordWidth-1:0] destY;
      logic [lengthWidth-1:0] length;
    } headerView;
    logic [dataWidth-1:0] payloadView;
  } flitData;

endpackage

//--- routing/routeCompute.sv
module routeCompute (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  logic [nocPkg::flitIdWidth-1:0] inFlitId [nocPkg::numPorts],
  input  logic [nocPkg::dataWidth-1:0] inData [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] inGrant,
  output logic [nocPkg::numPorts-1:0] request [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] headerStrobe,
  output logic [nocPkg::lengthWidth-1:0] packetLength [nocPkg::numPorts]
);

  nocPkg::flitData word [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] isHeader;
  logic [nocPkg::numPorts-1:0] isTail;
  logic [nocPkg::numPorts-1:0] taken;
  logic [nocPkg::numPorts-1:0] headerRoute [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] activeRoute [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] routeReg [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] lengthReg [nocPkg::numPorts];

  // Dimension order routing, X is resolved before Y
  function automatic logic [nocPkg::numPorts-1:0] xyRoute(
    input logic [nocPkg::coordWidth-1:0] destX,
    input logic [nocPkg::coordWidth-1:0] destY
  );
    logic [nocPkg::numPorts-1:0] route;
    route = '0;
    if (destX > nocPkg::routerX) begin
      route[nocPkg::portEast] = 1'b1;
    end else if (destX < nocPkg::routerX) begin
      route[nocPkg::portWest] = 1'b1;
    end else if (destY > nocPkg::routerY) begin
      route[nocPkg::portSouth] = 1'b1;
    end else if (destY < nocPkg::routerY) begin
      route[nocPkg::portNorth] = 1'b1;
    end else begin
      route[nocPkg::portLocal] = 1'b1;
    end
    return route;
  endfunction

  assign taken = inValid & inGrant;

  always_comb begin
    for (int i = 0; i < nocPkg::numPorts; i++) begin
      word[i] = inData[i];
      isHeader[i] = (inFlitId[i] == nocPkg::flitHeader);
      isTail[i] = (inFlitId[i] == nocPkg::flitTail);
      headerRoute[i] = xyRoute(word[i].headerView.destX, word[i].headerView.destY);
      // Header routes live, body and tail reuse the stored route
      activeRoute[i] = isHeader[i] ? headerRoute[i] : routeReg[i];
      headerStrobe[i] = inValid[i] && isHeader[i];
      packetLength[i] = isHeader[i] ? word[i].headerView.length : lengthReg[i];
    end
  end

  // Transpose into one request vector per output
  always_comb begin
    for (int o = 0; o < nocPkg::numPorts; o++) begin
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        request[o][i] = inValid[i] && activeRoute[i][o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        routeReg[i] <= '0;
      end
    end else begin
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        if (taken[i] && isHeader[i]) begin
          routeReg[i] <= headerRoute[i];
        end else if (taken[i] && isTail[i]) begin
          routeReg[i] <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < nocPkg::numPorts; i++) begin
      if (taken[i] && isHeader[i]) begin
        lengthReg[i] <= word[i].headerView.length;
      end
    end
  end

endmodule

//--- arbitration/outputArbiter.sv
module outputArbiter (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] request,
  input  logic [nocPkg::numPorts-1:0] headerStrobe,
  input  logic [nocPkg::lengthWidth-1:0] packetLength [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] grantSel
);

  // One-hot state, bit 0 is idle and bit i+1 grants input i
  logic [nocPkg::numPorts:0] state;
  logic [nocPkg::numPorts:0] nextState;
  logic [nocPkg::numPorts-1:0] lastServed;
  logic [nocPkg::numPorts-1:0] timesUp;
  logic [nocPkg::lengthWidth-1:0] holdLength [nocPkg::numPorts];
  logic [nocPkg::lengthWidth-1:0] count [nocPkg::numPorts];

  assign grantSel = state[nocPkg::numPorts:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= (nocPkg::numPorts + 1)'(1);
      // West counts as served, so Local leads after reset
      lastServed <= {1'b1, {(nocPkg::numPorts - 1){1'b0}}};
    end else begin
      state <= nextState;
      if (|nextState[nocPkg::numPorts:1]) begin
        lastServed <= nextState[nocPkg::numPorts:1];
      end
    end
  end

  always_comb begin
    int base;
    int span;
    int idx;
    logic found;
    base = 0;
    for (int i = 0; i < nocPkg::numPorts; i++) begin
      if (lastServed[i]) begin
        base = i;
      end
    end
    // A released input may not win straight back, an idle output may pick it
    span = state[0] ? nocPkg::numPorts : nocPkg::numPorts - 1;
    found = 1'b0;
    nextState = '0;

    // Keep the current packet until its timer runs out
    for (int i = 0; i < nocPkg::numPorts; i++) begin
      if (grantSel[i] && request[i] && !timesUp[i]) begin
        found = 1'b1;
        nextState[i + 1] = 1'b1;
      end
    end

    // Rotate from the input after the last one served
    for (int k = 1; k <= nocPkg::numPorts; k++) begin
      idx = (base + k) % nocPkg::numPorts;
      if (!found && k <= span && request[idx]) begin
        found = 1'b1;
        nextState[idx + 1] = 1'b1;
      end
    end

    if (!found) begin
      nextState[0] = 1'b1;
    end
  end

  // Packet timers, count is 1 in the first granted cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        count[i] <= nocPkg::lengthWidth'(1);
        holdLength[i] <= '0;
      end
    end else begin
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        if (headerStrobe[i]) begin
          holdLength[i] <= packetLength[i];
        end
        if (grantSel[i]) begin
          count[i] <= count[i] + 1'b1;
        end else begin
          count[i] <= nocPkg::lengthWidth'(1);
        end
      end
    end
  end

  // Last flit of the packet is going through this cycle
  always_comb begin
    for (int i = 0; i < nocPkg::numPorts; i++) begin
      timesUp[i] = (count[i] == holdLength[i]);
    end
  end

endmodule

//--- logic/crossbarSwitch.sv
module crossbarSwitch (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  logic [nocPkg::flitIdWidth-1:0] inFlitId [nocPkg::numPorts],
  input  logic [nocPkg::dataWidth-1:0] inData [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] grantSel [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inGrant,
  output logic [nocPkg::numPorts-1:0] outValid,
  output logic [nocPkg::flitIdWidth-1:0] outFlitId [nocPkg::numPorts],
  output logic [nocPkg::dataWidth-1:0] outData [nocPkg::numPorts]
);

  logic [nocPkg::numPorts-1:0] moveFlit;
  logic [nocPkg::flitIdWidth-1:0] muxFlitId [nocPkg::numPorts];
  logic [nocPkg::dataWidth-1:0] muxData [nocPkg::numPorts];

  // An input is granted when any output selects it
  always_comb begin
    inGrant = '0;
    for (int o = 0; o < nocPkg::numPorts; o++) begin
      inGrant = inGrant | grantSel[o];
    end
  end

  // Select the granted input per output
  always_comb begin
    for (int o = 0; o < nocPkg::numPorts; o++) begin
      moveFlit[o] = |(grantSel[o] & inValid);
      muxFlitId[o] = '0;
      muxData[o] = '0;
      for (int i = 0; i < nocPkg::numPorts; i++) begin
        if (grantSel[o][i]) begin
          muxFlitId[o] = inFlitId[i];
          muxData[o] = inData[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      outValid <= moveFlit;
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < nocPkg::numPorts; o++) begin
      if (moveFlit[o]) begin
        outFlitId[o] <= muxFlitId[o];
        outData[o] <= muxData[o];
      end
    end
  end

endmodule

//--- logic/meshRouter.sv
module meshRouter (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] inValid,
  input  logic [nocPkg::flitIdWidth-1:0] inFlitId [nocPkg::numPorts],
  input  logic [nocPkg::dataWidth-1:0] inData [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] inGrant,
  output logic [nocPkg::numPorts-1:0] outValid,
  output logic [nocPkg::flitIdWidth-1:0] outFlitId [nocPkg::numPorts],
  output logic [nocPkg::dataWidth-1:0] outData [nocPkg::numPorts]
);

  // Request and grant vectors are indexed by output, bits by input
  logic [nocPkg::numPorts-1:0] request [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] grantSel [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] headerStrobe;
  logic [nocPkg::lengthWidth-1:0] packetLength [nocPkg::numPorts];

  routeCompute i_routeCompute (
    .clk          (clk),
    .rst          (rst),
    .inValid      (inValid),
    .inFlitId     (inFlitId),
    .inData       (inData),
    .inGrant      (inGrant),
    .request      (request),
    .headerStrobe (headerStrobe),
    .packetLength (packetLength)
  );

  // One arbiter per output port
  for (genvar o = 0; o < nocPkg::numPorts; o++) begin : arbiterGen
    outputArbiter i_outputArbiter (
      .clk          (clk),
      .rst          (rst),
      .request      (request[o]),
      .headerStrobe (headerStrobe),
      .packetLength (packetLength),
      .grantSel     (grantSel[o])
    );
  end

  crossbarSwitch i_crossbarSwitch (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .grantSel  (grantSel),
    .inGrant   (inGrant),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

endmodule

//--- verification/routerTb.sv
module routerTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 10;
  localparam int numPorts = nocPkg::numPorts;
  localparam int numPackets = 40;
  localparam int maxLength = 8;
  localparam int entryWidth = nocPkg::flitIdWidth + nocPkg::dataWidth;
  // Five budgets of maxLength flits per port and packet
  localparam int watchdogTime = 5 * maxLength * numPorts * numPackets * clkPeriod;

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [nocPkg::flitIdWidth-1:0] inFlitId [numPorts];
  logic [nocPkg::dataWidth-1:0] inData [numPorts];
  logic [numPorts-1:0] inGrant;
  logic [numPorts-1:0] outValid;
  logic [nocPkg::flitIdWidth-1:0] outFlitId [numPorts];
  logic [nocPkg::dataWidth-1:0] outData [numPorts];

  integer seed;
  logic running;
  int delivered;

  // Source state
  logic [numPorts-1:0] takenNow;
  logic [numPorts-1:0] srcActive;
  int sentCount [numPorts];
  int flitPos [numPorts];
  int pktLen [numPorts];
  int gapLeft [numPorts];
  int curRoute [numPorts];

  // Reference model with one queue per output and source pair
  logic [entryWidth-1:0] expQ [numPorts*numPorts][$];
  int pendSrc [numPorts];
  logic [numPorts-1:0] waitPrev [numPorts];
  int lastServed [numPorts];
  logic [numPorts-1:0] pktOpen;
  int openSrc [numPorts];
  int remaining [numPorts];

  meshRouter i_meshRouter (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlitId  (inFlitId),
    .inData    (inData),
    .inGrant   (inGrant),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task checkValue(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // XY order leaves along X first and then along Y
  function automatic int xyPort(input int destX, input int destY);
    int port;
    if (destX != int'(nocPkg::routerX)) begin
      port = (destX > int'(nocPkg::routerX)) ? nocPkg::portEast : nocPkg::portWest;
    end else if (destY != int'(nocPkg::routerY)) begin
      port = (destY > int'(nocPkg::routerY)) ? nocPkg::portSouth : nocPkg::portNorth;
    end else begin
      port = nocPkg::portLocal;
    end
    return port;
  endfunction

  // Closest waiting input after the last served one, which itself comes last
  function automatic int rotateWinner(input logic [numPorts-1:0] waiting, input int last);
    int winner;
    int cand;
    winner = -1;
    for (int k = numPorts; k >= 1; k--) begin
      cand = (last + k) % numPorts;
      if (waiting[cand]) begin
        winner = cand;
      end
    end
    return winner;
  endfunction

  function automatic logic allSent();
    logic done;
    done = (srcActive == '0);
    for (int p = 0; p < numPorts; p++) begin
      done = done && (sentCount[p] == numPackets);
    end
    return done;
  endfunction

  task startPacket(input int s);
    int destX;
    int destY;
    int len;
    destX = $unsigned($random(seed)) % nocPkg::meshWidth;
    destY = $unsigned($random(seed)) % nocPkg::meshHeight;
    len = 1 + $unsigned($random(seed)) % maxLength;
    pktLen[s] = len;
    flitPos[s] = 0;
    curRoute[s] = xyPort(destX, destY);
    srcActive[s] = 1'b1;
    inValid[s] <= 1'b1;
    inFlitId[s] <= nocPkg::flitHeader;
    inData[s] <= {nocPkg::coordWidth'(destX), nocPkg::coordWidth'(destY),
                  nocPkg::lengthWidth'(len)};
  endtask

  // Presents the next flit or ends the packet once a flit was taken
  task nextFlit(input int s);
    flitPos[s]++;
    if (flitPos[s] == pktLen[s]) begin
      srcActive[s] = 1'b0;
      sentCount[s]++;
      inValid[s] <= 1'b0;
      gapLeft[s] = $unsigned($random(seed)) % 4;
      if (gapLeft[s] == 0 && sentCount[s] < numPackets) begin
        startPacket(s);
      end
    end else begin
      inFlitId[s] <= (flitPos[s] == pktLen[s] - 1) ? nocPkg::flitTail : nocPkg::flitBody;
      inData[s] <= nocPkg::dataWidth'($random(seed));
    end
  endtask

  // An open packet continues from its own source and a new one from the last taken input
  task arrive(input int o, input int taker);
    logic [entryWidth-1:0] expected;
    int s;
    int q;
    s = pktOpen[o] ? openSrc[o] : taker;
    q = o * numPorts + s;
    checkValue(expQ[q].size(), 1, $sformatf("flits queued for port %0d from %0d", o, s));
    expected = expQ[q].pop_front();
    checkValue(int'(outFlitId[o]), int'(expected[entryWidth-1:nocPkg::dataWidth]),
               $sformatf("flit kind on port %0d", o));
    checkValue(int'(outData[o]), int'(expected[nocPkg::dataWidth-1:0]),
               $sformatf("flit data on port %0d", o));
    if (pktOpen[o]) begin
      remaining[o]--;
    end else begin
      checkValue(int'(outFlitId[o]), int'(nocPkg::flitHeader), "first flit of a packet");
      openSrc[o] = s;
      remaining[o] = int'(expected[nocPkg::lengthWidth-1:0]) - 1;
    end
    pktOpen[o] = (remaining[o] > 0);
    if (!pktOpen[o]) begin
      delivered++;
    end
  endtask

  // Sources move on only after a flit was seen taken
  always @(posedge clk) begin
    if (running) begin
      for (int s = 0; s < numPorts; s++) begin
        if (srcActive[s]) begin
          if (takenNow[s]) begin
            nextFlit(s);
          end
        end else if (sentCount[s] < numPackets) begin
          if (gapLeft[s] > 0) begin
            gapLeft[s]--;
          end else begin
            startPacket(s);
          end
        end
      end
    end
  end

  always @(negedge clk) begin : modelStep
    int route;
    logic [numPorts-1:0] claimed;
    if (!rst) begin
      takenNow = inValid & inGrant;
      if (!running) begin
        checkValue(int'(outValid), 0, "outValid before traffic");
        checkValue(int'(inGrant), 0, "inGrant before traffic");
      end
      // Output flits are the ones taken one cycle earlier
      for (int o = 0; o < numPorts; o++) begin
        checkValue(int'(outValid[o]), int'(pendSrc[o] >= 0), $sformatf("outValid on port %0d", o));
        if (pendSrc[o] >= 0) begin
          arrive(o, pendSrc[o]);
        end else begin
          checkValue(int'(pktOpen[o]), 0, $sformatf("gap inside packet on port %0d", o));
        end
        pendSrc[o] = -1;
      end
      claimed = '0;
      for (int s = 0; s < numPorts; s++) begin
        if (takenNow[s]) begin
          route = curRoute[s];
          checkValue(int'(claimed[route]), 0, $sformatf("inputs granted to port %0d", route));
          claimed[route] = 1'b1;
          pendSrc[route] = s;
          expQ[route * numPorts + s].push_back({inFlitId[s], inData[s]});
          if (inFlitId[s] == nocPkg::flitHeader) begin
            checkValue(s, rotateWinner(waitPrev[route], lastServed[route]),
                       $sformatf("round robin winner on port %0d", route));
            lastServed[route] = s;
          end
        end
      end
      // Headers still waiting compete for the next grant
      for (int o = 0; o < numPorts; o++) begin
        waitPrev[o] = '0;
      end
      for (int s = 0; s < numPorts; s++) begin
        if (inValid[s] && !takenNow[s] && inFlitId[s] == nocPkg::flitHeader) begin
          waitPrev[curRoute[s]][s] = 1'b1;
        end
      end
    end
  end

  initial begin
    #(watchdogTime);
    $display("Timeout: not every packet was delivered within %0d ns", watchdogTime);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    seed = 32'hd532_f67c;
    rst = 1'b1;
    running = 1'b0;
    delivered = 0;
    inValid = '0;
    takenNow = '0;
    srcActive = '0;
    pktOpen = '0;
    for (int p = 0; p < numPorts; p++) begin
      inFlitId[p] = '0;
      inData[p] = '0;
      sentCount[p] = 0;
      flitPos[p] = 0;
      pktLen[p] = 0;
      curRoute[p] = 0;
      gapLeft[p] = $unsigned($random(seed)) % 4;
      pendSrc[p] = -1;
      waitPrev[p] = '0;
      // West counts as served so Local leads first
      lastServed[p] = nocPkg::portWest;
      openSrc[p] = 0;
      remaining[p] = 0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    running <= 1'b1;
    while (!allSent()) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
    for (int q = 0; q < numPorts * numPorts; q++) begin
      checkValue(expQ[q].size(), 0, "flits left undelivered");
    end
    checkValue(delivered, numPorts * numPackets, "packets delivered");
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- meshRouter.f
common/nocPkg.sv
routing/routeCompute.sv
arbitration/outputArbiter.sv
logic/crossbarSwitch.sv
logic/meshRouter.sv
verification/routerTb.sv

//--- Makefile
TOOL       = verilator
TOP        = routerTb
FILELIST   = meshRouter.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = ERRORS FOUND
PASS_MSG   = NO ERRORS

COMMON_FLAGS = --timing --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   = --lint-only -Wall
SIM_FLAGS    = --binary -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(COMMON_FLAGS)

build:
	$(TOOL) $(SIM_FLAGS) $(COMMON_FLAGS)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
